// File: sp_data_bus.f
logic/sp_bus_pkg.sv
logic/sp_mmio_pkg.sv
logic/sp_byte_bridge.sv
logic/sp_local_ram.sv
logic/sp_mmio_regs.sv
logic/sp_data_bus.sv
verif/tb_clk_gen.sv
verif/sp_data_bus_tb.sv

// File: run.sh
#!/bin/sh
# build and run the data bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   -f sp_data_bus.f --top-module sp_data_bus_tb -o sp_data_bus_sim

out=$(./obj_dir/sp_data_bus_sim)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***'

// File: verif/sp_data_bus_tb.sv
`timescale 1ns/1ps

module sp_data_bus_tb;

   localparam int N_ACC      = 400;
   localparam int N_INIT     = sp_bus_pkg::RAM_WORDS;
   localparam int MAX_CYCLES = (N_ACC + N_INIT) * 20 + 100;
   localparam logic [23:0] EXT_BASE = 24'h5a_3c00;

   logic        clk, arst_n;
   logic [31:0] dbus_adr, dbus_dat_w, dbus_dat_r;
   logic [0:3]  dbus_sel;
   logic        dbus_we, dbus_cyc, dbus_stb, dbus_ack;
   logic [23:0] wb_adr;
   logic [7:0]  wb_dat_w;
   logic [7:0]  wb_dat_r = 8'h00;
   logic [0:0]  wb_sel;
   logic        wb_we, wb_stb, wb_cyc;
   logic        wb_ack = 1'b0;
   logic [2:0]  drive_act;
   logic        led_green, led_red;
   logic [4:0]  sw_reset;
   logic [23:0] rgb1, rgb2;

   integer      seed = 32'hc5ac_5966;
   integer      wait_seed = 32'hc5ac_5966;
   int          errors, checks;
   int          cycles = 0;
   int          slave_wait = 0;
   int          rd_lat;
   logic [31:0] rd_dat;
   logic [31:0] ram_model [0:255];
   logic [7:0]  ext_model [logic [23:0]];
   logic [7:0]  slave_mem [logic [23:0]];
   logic [23:0] cyc_adr [$];
   logic [7:0]  cyc_dat [$];
   logic        cyc_sel [$];
   logic        cyc_we [$];
   logic [6:0]  ctrl_m;
   logic [23:0] rgb1_m, rgb2_m;
   logic [31:0] last_ticks;

   tb_clk_gen i_tb_clk_gen (.clk(clk), .arst_n_o(arst_n));

   sp_data_bus i_sp_data_bus (
      .clk(clk), .arst_n_i(arst_n),
      .dbus_adr_i(dbus_adr), .dbus_dat_i(dbus_dat_w), .dbus_sel_i(dbus_sel),
      .dbus_we_i(dbus_we), .dbus_cyc_i(dbus_cyc), .dbus_stb_i(dbus_stb),
      .dbus_dat_o(dbus_dat_r), .dbus_ack_o(dbus_ack),
      .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w), .wb_dat_i(wb_dat_r), .wb_we_o(wb_we),
      .wb_sel_o(wb_sel), .wb_stb_o(wb_stb), .wb_cyc_o(wb_cyc), .wb_ack_i(wb_ack),
      .drive_activity_i(drive_act), .led_green_o(led_green), .led_red_o(led_red),
      .sw_reset_o(sw_reset), .led1_rgb_o(rgb1), .led2_rgb_o(rgb2)
   );

   // unwritten external bytes
   function automatic logic [7:0] fill_byte(input logic [23:0] a);
      return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h3c;
   endfunction

   function automatic logic [7:0] ext_byte(input logic [23:0] a);
      if (ext_model.exists(a)) begin
         return ext_model[a];
      end
      return fill_byte(a);
   endfunction

   // byte k is the k-th most significant byte, enabled by sel[k]
   function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [0:3] sel);
      logic [31:0] res;
      res = old_w;
      for (int k = 0; k < 4; k++) begin
         if (sel[k]) res[31-8*k -: 8] = new_w[31-8*k -: 8];
      end
      return res;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("error %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_true(input bit ok, input string what);
      checks++;
      assert (ok) else begin
         errors++;
         $display("error %0t %s", $time, what);
      end
   endtask

   task automatic check_quiet_outputs();
      check_val("dbus_ack_o", 32'(dbus_ack), 32'h0);
      check_val("wb_cyc_o", 32'(wb_cyc), 32'h0);
      check_val("wb_stb_o", 32'(wb_stb), 32'h0);
      check_val("led_green_o", 32'(led_green), 32'h0);
      check_val("led_red_o", 32'(led_red), 32'h0);
      check_val("sw_reset_o", 32'(sw_reset), 32'h0);
      check_val("led1_rgb_o", 32'(rgb1), 32'h0);
      check_val("led2_rgb_o", 32'(rgb2), 32'h0);
   endtask

   task automatic check_mmio_outputs();
      check_val("led_green_o", 32'(led_green), 32'(ctrl_m[6]));
      check_val("led_red_o", 32'(led_red), 32'(ctrl_m[5]));
      check_val("sw_reset_o", 32'(sw_reset), 32'(ctrl_m[4:0]));
      check_val("led1_rgb_o", 32'(rgb1), 32'(rgb1_m));
      check_val("led2_rgb_o", 32'(rgb2), 32'(rgb2_m));
   endtask

   // one classic cycle, ends on ack, stb low for a cycle after
   task automatic bus_access(input logic [31:0] adr, input logic [31:0] dat,
                             input logic [0:3] sel, input logic we);
      @(posedge clk);
      dbus_adr   <= adr;
      dbus_dat_w <= dat;
      dbus_sel   <= sel;
      dbus_we    <= we;
      dbus_cyc   <= 1'b1;
      dbus_stb   <= 1'b1;
      rd_lat = 0;
      @(negedge clk);
      while (!dbus_ack) begin
         rd_lat++;
         @(negedge clk);
      end
      rd_dat = dbus_dat_r;
      @(posedge clk);
      dbus_cyc <= 1'b0;
      dbus_stb <= 1'b0;
   endtask

   // byte slave with 0 to 3 wait cycles per byte
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_ack     <= 1'b0;
         slave_wait <= 0;
      end else if (wb_ack) begin
         wb_ack <= 1'b0;
      end else if (wb_stb && wb_cyc) begin
         if (slave_wait > 0) begin
            slave_wait <= slave_wait - 1;
         end else begin
            wb_ack     <= 1'b1;
            slave_wait <= int'($unsigned($random(wait_seed)) % 4);
            cyc_adr.push_back(wb_adr);
            cyc_dat.push_back(wb_dat_w);
            cyc_sel.push_back(wb_sel[0]);
            cyc_we.push_back(wb_we);
            if (wb_we && wb_sel[0]) slave_mem[wb_adr] = wb_dat_w;
            wb_dat_r <= slave_mem.exists(wb_adr) ? slave_mem[wb_adr] : fill_byte(wb_adr);
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout after %0d cycles, an access never completed", cycles);
         $display("*** FAILED ***");
         $finish;
      end
   end

   initial begin
      int          kind;
      logic [31:0] r, dat, exp, w;
      logic [0:3]  sel;
      logic        we;
      logic [23:0] ea;
      logic [2:0]  off;
      errors = 0;
      checks = 0;
      dbus_adr = '0;
      dbus_dat_w = '0;
      dbus_sel = '0;
      dbus_we = 1'b0;
      dbus_cyc = 1'b0;
      dbus_stb = 1'b0;
      drive_act = 3'd0;
      ctrl_m = '0;
      rgb1_m = '0;
      rgb2_m = '0;
      last_ticks = '0;

      @(negedge clk);
      while (arst_n !== 1'b1) begin
         check_quiet_outputs();
         @(negedge clk);
      end
      check_quiet_outputs();

      for (int i = 0; i < N_INIT; i++) begin
         w = $random(seed);
         bus_access(32'(i) << 2, w, 4'b1111, 1'b1);
         ram_model[i] = w;
      end

      for (int n = 0; n < N_ACC; n++) begin
         kind = int'($unsigned($random(seed)) % 4);
         r    = $random(seed);
         dat  = $random(seed);
         sel  = 4'($random(seed));
         we   = 1'($random(seed));
         @(posedge clk);
         drive_act <= 3'($random(seed));
         cyc_adr.delete();
         cyc_dat.delete();
         cyc_sel.delete();
         cyc_we.delete();
         case (kind)
            0: begin
               bus_access(r & 32'h7fff_fffc, dat, sel, we);
               check_true(rd_lat == 1, "local RAM ack did not come one cycle after the strobe");
               if (we) begin
                  ram_model[r[9:2]] = merge_lanes(ram_model[r[9:2]], dat, sel);
               end else begin
                  check_val("dbus_dat_o", rd_dat, ram_model[r[9:2]]);
               end
               check_true(cyc_adr.size() == 0, "local RAM access started a byte-bus cycle");
            end
            1: begin
               ea = EXT_BASE + 24'((r % 16) * 4);
               bus_access({8'h80, ea}, dat, sel, we);
               exp = '0;
               check_true(cyc_adr.size() == 4, "external access did not make four byte cycles");
               for (int k = 0; k < 4 && k < cyc_adr.size(); k++) begin
                  check_val("wb_adr_o", 32'(cyc_adr[k]), 32'(ea + 24'(k)));
                  check_val("wb_we_o", 32'(cyc_we[k]), 32'(we));
                  if (we) begin
                     check_val("wb_dat_o", 32'(cyc_dat[k]), 32'(dat[31-8*k -: 8]));
                     check_val("wb_sel_o", 32'(cyc_sel[k]), 32'(sel[k]));
                  end
               end
               for (int k = 0; k < 4; k++) begin
                  if (we && sel[k]) ext_model[ea + 24'(k)] = dat[31-8*k -: 8];
                  exp[31-8*k -: 8] = ext_byte(ea + 24'(k));
               end
               if (!we) check_val("dbus_dat_o", rd_dat, exp);
            end
            2: begin
               off = 3'(r % 8);
               bus_access({8'hff, r[23:5], off, 2'b00}, dat, sel, we);
               check_true(rd_lat == 1, "register ack did not come one cycle after the strobe");
               if (we) begin
                  if (off == 3'd0) begin
                     w = merge_lanes({25'b0, ctrl_m}, dat, sel);
                     ctrl_m = w[6:0];
                  end else if (off == 3'd1) begin
                     w = merge_lanes({8'b0, rgb1_m}, dat, sel);
                     rgb1_m = w[23:0];
                  end else if (off == 3'd2) begin
                     w = merge_lanes({8'b0, rgb2_m}, dat, sel);
                     rgb2_m = w[23:0];
                  end
               end else if (off == 3'd4) begin
                  check_true(rd_dat > last_ticks, "tick counter did not increase between reads");
                  last_ticks = rd_dat;
               end else begin
                  case (off)
                     3'd0:    exp = {25'b0, ctrl_m};
                     3'd1:    exp = {8'b0, rgb1_m};
                     3'd2:    exp = {8'b0, rgb2_m};
                     3'd3:    exp = {29'b0, drive_act};
                     default: exp = '0;
                  endcase
                  check_val("dbus_dat_o", rd_dat, exp);
               end
               check_mmio_outputs();
            end
            default: begin
               bus_access({8'h81 + 8'(r % 126), r[23:0]}, dat, sel, we);
               check_true(rd_lat == 1, "unmapped ack did not come one cycle after the strobe");
               check_val("dbus_dat_o", rd_dat, 32'h0);
               check_true(cyc_adr.size() == 0, "unmapped access started a byte-bus cycle");
            end
         endcase
      end

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk,
   output logic arst_n_o
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period
   end

   initial begin
      arst_n_o = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n_o = 1'b1;   // released away from the rising edge
   end

endmodule

// File: logic/sp_data_bus.sv
`timescale 1ns/1ps

module sp_data_bus (
   input  logic                                    clk,
   input  logic                                    arst_n_i,
   input  logic [0:sp_bus_pkg::ADR_W-1]            dbus_adr_i,
   input  logic [0:sp_bus_pkg::DATA_W-1]           dbus_dat_i,
   input  logic [0:sp_bus_pkg::SEL_W-1]            dbus_sel_i,
   input  logic                                    dbus_we_i,
   input  logic                                    dbus_cyc_i,
   input  logic                                    dbus_stb_i,
   output logic [0:sp_bus_pkg::DATA_W-1]           dbus_dat_o,
   output logic                                    dbus_ack_o,
   output logic [0:sp_bus_pkg::BYTE_ADR_W-1]       wb_adr_o,
   output logic [0:sp_bus_pkg::BYTE_W-1]           wb_dat_o,
   input  logic [0:sp_bus_pkg::BYTE_W-1]           wb_dat_i,
   output logic                                    wb_we_o,
   output logic [0:0]                              wb_sel_o,
   output logic                                    wb_stb_o,
   output logic                                    wb_cyc_o,
   input  logic                                    wb_ack_i,
   input  logic [0:sp_mmio_pkg::STATUS_W-1]        drive_activity_i,
   output logic                                    led_green_o,
   output logic                                    led_red_o,
   output logic [0:sp_mmio_pkg::SW_RESET_W-1]      sw_reset_o,
   output logic [0:sp_mmio_pkg::RGB_W-1]           led1_rgb_o,
   output logic [0:sp_mmio_pkg::RGB_W-1]           led2_rgb_o
);

   logic                            strobe;
   logic                            hit_ram, hit_ext, hit_mmio, hit_none;
   logic                            ram_ack, ext_ack, mmio_ack, none_ack_q;
   logic [0:sp_bus_pkg::DATA_W-1]   ram_dat, ext_dat, mmio_dat;

   assign strobe   = dbus_cyc_i && dbus_stb_i;
   assign hit_ram  = !dbus_adr_i[0];                          // lower half
   assign hit_ext  = dbus_adr_i[0:7] == sp_bus_pkg::REGION_EXT;
   assign hit_mmio = dbus_adr_i[0:7] == sp_bus_pkg::REGION_MMIO;
   assign hit_none = !hit_ram && !hit_ext && !hit_mmio;

   // unmapped accesses still complete, one cycle late
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         none_ack_q <= 1'b0;
      end else begin
         none_ack_q <= strobe && hit_none && !none_ack_q;
      end
   end

   assign dbus_ack_o = ram_ack | ext_ack | mmio_ack | none_ack_q;
   assign dbus_dat_o = hit_ram  ? ram_dat :
                       hit_ext  ? ext_dat :
                       hit_mmio ? mmio_dat : '0;

   sp_local_ram i_sp_local_ram (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .stb_i    (strobe && hit_ram),
      .adr_i    (dbus_adr_i[sp_bus_pkg::ADR_W-2-sp_bus_pkg::RAM_ADDR_BITS:sp_bus_pkg::ADR_W-3]),
      .dat_i    (dbus_dat_i),
      .be_i     (dbus_sel_i),
      .we_i     (dbus_we_i),
      .ack_o    (ram_ack),
      .dat_o    (ram_dat)
   );

   sp_byte_bridge i_sp_byte_bridge (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .sel_i    (strobe && hit_ext),
      .cyc_i    (dbus_cyc_i && hit_ext),
      .adr_i    (dbus_adr_i[8:sp_bus_pkg::ADR_W-3]),   // word address below the region byte
      .dat_i    (dbus_dat_i),
      .be_i     (dbus_sel_i),
      .we_i     (dbus_we_i),
      .ack_o    (ext_ack),
      .dat_o    (ext_dat),
      .wb_adr_o (wb_adr_o),
      .wb_dat_o (wb_dat_o),
      .wb_dat_i (wb_dat_i),
      .wb_we_o  (wb_we_o),
      .wb_sel_o (wb_sel_o),
      .wb_stb_o (wb_stb_o),
      .wb_cyc_o (wb_cyc_o),
      .wb_ack_i (wb_ack_i)
   );

   sp_mmio_regs i_sp_mmio_regs (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .stb_i            (strobe && hit_mmio),
      .adr_i            (dbus_adr_i[sp_bus_pkg::ADR_W-2-sp_mmio_pkg::REG_ADR_W:sp_bus_pkg::ADR_W-3]),
      .dat_i            (dbus_dat_i),
      .be_i             (dbus_sel_i),
      .we_i             (dbus_we_i),
      .ack_o            (mmio_ack),
      .dat_o            (mmio_dat),
      .drive_activity_i (drive_activity_i),
      .led_green_o      (led_green_o),
      .led_red_o        (led_red_o),
      .sw_reset_o       (sw_reset_o),
      .led1_rgb_o       (led1_rgb_o),
      .led2_rgb_o       (led2_rgb_o)
   );

   // only one target may answer a given access
   a_one_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
      $onehot0({ram_ack, ext_ack, mmio_ack, none_ack_q}));

endmodule

// File: logic/sp_mmio_regs.sv
`timescale 1ns/1ps

module sp_mmio_regs (
   input  logic                                    clk,
   input  logic                                    arst_n_i,
   input  logic                                    stb_i,
   input  logic [0:sp_mmio_pkg::REG_ADR_W-1]       adr_i,
   input  logic [0:sp_bus_pkg::DATA_W-1]           dat_i,
   input  logic [0:sp_bus_pkg::SEL_W-1]            be_i,
   input  logic                                    we_i,
   output logic                                    ack_o,
   output logic [0:sp_bus_pkg::DATA_W-1]           dat_o,
   input  logic [0:sp_mmio_pkg::STATUS_W-1]        drive_activity_i,
   output logic                                    led_green_o,
   output logic                                    led_red_o,
   output logic [0:sp_mmio_pkg::SW_RESET_W-1]      sw_reset_o,
   output logic [0:sp_mmio_pkg::RGB_W-1]           led1_rgb_o,
   output logic [0:sp_mmio_pkg::RGB_W-1]           led2_rgb_o
);

   logic [0:sp_mmio_pkg::CTRL_W-1]   ctrl_q;
   logic [0:sp_mmio_pkg::RGB_W-1]    rgb1_q;
   logic [0:sp_mmio_pkg::RGB_W-1]    rgb2_q;
   logic [0:sp_bus_pkg::DATA_W-1]    ticks_q;
   logic [0:sp_bus_pkg::DATA_W-1]    ctrl_word;
   logic [0:sp_bus_pkg::DATA_W-1]    rgb1_word;
   logic [0:sp_bus_pkg::DATA_W-1]    rgb2_word;
   logic [0:sp_bus_pkg::DATA_W-1]    stat_word;
   logic [0:sp_bus_pkg::DATA_W-1]    ctrl_wr;
   logic [0:sp_bus_pkg::DATA_W-1]    rgb1_wr;
   logic [0:sp_bus_pkg::DATA_W-1]    rgb2_wr;
   logic                             serve;

   function automatic logic [0:sp_bus_pkg::DATA_W-1] merge_bytes(
      input logic [0:sp_bus_pkg::DATA_W-1] cur,
      input logic [0:sp_bus_pkg::DATA_W-1] wr,
      input logic [0:sp_bus_pkg::SEL_W-1]  be
   );
      logic [0:sp_bus_pkg::DATA_W-1] res;
      res = cur;
      for (int b = 0; b < sp_bus_pkg::SEL_W; b++) begin
         if (be[b]) begin
            res[sp_bus_pkg::BYTE_W*b +: sp_bus_pkg::BYTE_W] =
               wr[sp_bus_pkg::BYTE_W*b +: sp_bus_pkg::BYTE_W];
         end
      end
      return res;
   endfunction

   // registers right-aligned in the 32-bit word
   assign ctrl_word = {{(sp_bus_pkg::DATA_W-sp_mmio_pkg::CTRL_W){1'b0}}, ctrl_q};
   assign rgb1_word = {{(sp_bus_pkg::DATA_W-sp_mmio_pkg::RGB_W){1'b0}}, rgb1_q};
   assign rgb2_word = {{(sp_bus_pkg::DATA_W-sp_mmio_pkg::RGB_W){1'b0}}, rgb2_q};
   assign stat_word = {{(sp_bus_pkg::DATA_W-sp_mmio_pkg::STATUS_W){1'b0}}, drive_activity_i};

   assign ctrl_wr = merge_bytes(ctrl_word, dat_i, be_i);
   assign rgb1_wr = merge_bytes(rgb1_word, dat_i, be_i);
   assign rgb2_wr = merge_bytes(rgb2_word, dat_i, be_i);

   assign serve = stb_i && !ack_o;

   assign led_green_o = ctrl_q[0];
   assign led_red_o   = ctrl_q[1];
   assign sw_reset_o  = ctrl_q[2:sp_mmio_pkg::CTRL_W-1];
   assign led1_rgb_o  = rgb1_q;
   assign led2_rgb_o  = rgb2_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o   <= 1'b0;
         ctrl_q  <= sp_mmio_pkg::CTRL_RESET;
         rgb1_q  <= '0;
         rgb2_q  <= '0;
         ticks_q <= '0;
      end else begin
         ack_o   <= serve;
         ticks_q <= ticks_q + 1'b1;
         if (serve && we_i) begin
            case (adr_i)
               sp_mmio_pkg::REG_CTRL:
                  ctrl_q <= ctrl_wr[sp_bus_pkg::DATA_W-sp_mmio_pkg::CTRL_W:sp_bus_pkg::DATA_W-1];
               sp_mmio_pkg::REG_RGB1:
                  rgb1_q <= rgb1_wr[sp_bus_pkg::DATA_W-sp_mmio_pkg::RGB_W:sp_bus_pkg::DATA_W-1];
               sp_mmio_pkg::REG_RGB2:
                  rgb2_q <= rgb2_wr[sp_bus_pkg::DATA_W-sp_mmio_pkg::RGB_W:sp_bus_pkg::DATA_W-1];
               default: ;   // status and ticks are read-only
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (serve) begin
         case (adr_i)
            sp_mmio_pkg::REG_CTRL:   dat_o <= ctrl_word;
            sp_mmio_pkg::REG_RGB1:   dat_o <= rgb1_word;
            sp_mmio_pkg::REG_RGB2:   dat_o <= rgb2_word;
            sp_mmio_pkg::REG_STATUS: dat_o <= stat_word;
            sp_mmio_pkg::REG_TICKS:  dat_o <= ticks_q;
            default:                 dat_o <= '0;
         endcase
      end
   end

endmodule

// File: logic/sp_local_ram.sv
`timescale 1ns/1ps

module sp_local_ram (
   input  logic                                    clk,
   input  logic                                    arst_n_i,
   input  logic                                    stb_i,
   input  logic [0:sp_bus_pkg::RAM_ADDR_BITS-1]    adr_i,
   input  logic [0:sp_bus_pkg::DATA_W-1]           dat_i,
   input  logic [0:sp_bus_pkg::SEL_W-1]            be_i,
   input  logic                                    we_i,
   output logic                                    ack_o,
   output logic [0:sp_bus_pkg::DATA_W-1]           dat_o
);

   logic [0:sp_bus_pkg::DATA_W-1] mem_q [0:sp_bus_pkg::RAM_WORDS-1];
   logic                          serve;

   // a strobe still high during the ack is the same access
   assign serve = stb_i && !ack_o;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= serve;
      end
   end

   always_ff @(posedge clk) begin
      if (serve) begin
         if (we_i) begin
            for (int b = 0; b < sp_bus_pkg::SEL_W; b++) begin
               if (be_i[b]) begin
                  mem_q[adr_i][sp_bus_pkg::BYTE_W*b +: sp_bus_pkg::BYTE_W] <=
                     dat_i[sp_bus_pkg::BYTE_W*b +: sp_bus_pkg::BYTE_W];
               end
            end
         end
         dat_o <= mem_q[adr_i];   // old word on a write
      end
   end

endmodule

// File: logic/sp_byte_bridge.sv
`timescale 1ns/1ps

module sp_byte_bridge (
   input  logic                                    clk,
   input  logic                                    arst_n_i,
   input  logic                                    sel_i,
   input  logic                                    cyc_i,
   input  logic [0:sp_bus_pkg::BYTE_ADR_W-3]       adr_i,
   input  logic [0:sp_bus_pkg::DATA_W-1]           dat_i,
   input  logic [0:sp_bus_pkg::SEL_W-1]            be_i,
   input  logic                                    we_i,
   output logic                                    ack_o,
   output logic [0:sp_bus_pkg::DATA_W-1]           dat_o,
   output logic [0:sp_bus_pkg::BYTE_ADR_W-1]       wb_adr_o,
   output logic [0:sp_bus_pkg::BYTE_W-1]           wb_dat_o,
   input  logic [0:sp_bus_pkg::BYTE_W-1]           wb_dat_i,
   output logic                                    wb_we_o,
   output logic [0:0]                              wb_sel_o,
   output logic                                    wb_stb_o,
   output logic                                    wb_cyc_o,
   input  logic                                    wb_ack_i
);

   logic [0:1]                     sub_q;      // byte lane in flight
   logic [0:sp_bus_pkg::DATA_W-1]  shift_q;
   logic                           ack_q;
   logic                           byte_done;

   assign byte_done = wb_stb_o && wb_ack_i;

   assign wb_adr_o = {adr_i, sub_q};
   assign wb_dat_o = dat_i[sp_bus_pkg::BYTE_W*sub_q +: sp_bus_pkg::BYTE_W];
   assign wb_sel_o = be_i[sub_q];
   assign wb_we_o  = we_i;
   assign wb_stb_o = sel_i && !ack_q;   // quiet while the word ack is out
   assign wb_cyc_o = cyc_i;

   assign ack_o = ack_q;
   assign dat_o = shift_q;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
         sub_q <= 2'd0;
      end else if (ack_q || !sel_i) begin
         ack_q <= 1'b0;
         sub_q <= 2'd0;
      end else if (byte_done) begin
         ack_q <= (sub_q == 2'd3);   // fourth byte closes the word
         sub_q <= sub_q + 2'd1;
      end
   end

   // first byte ends up in the top lane
   always_ff @(posedge clk) begin
      if (byte_done) begin
         shift_q <= {shift_q[sp_bus_pkg::BYTE_W:sp_bus_pkg::DATA_W-1], wb_dat_i};
      end
   end

   // a waiting byte keeps its address and data
   a_hold_on_wait: assert property (@(posedge clk) disable iff (!arst_n_i)
      wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_dat_o));

   a_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n_i)
      wb_stb_o |-> wb_cyc_o);

endmodule

// File: logic/sp_mmio_pkg.sv
package sp_mmio_pkg;

   localparam int REG_ADR_W = 3;    // word offset inside the register region

   localparam logic [0:REG_ADR_W-1] REG_CTRL   = 3'd0;
   localparam logic [0:REG_ADR_W-1] REG_RGB1   = 3'd1;
   localparam logic [0:REG_ADR_W-1] REG_RGB2   = 3'd2;
   localparam logic [0:REG_ADR_W-1] REG_STATUS = 3'd3;   // read-only
   localparam logic [0:REG_ADR_W-1] REG_TICKS  = 3'd4;   // read-only

   localparam int SW_RESET_W = 5;
   localparam int RGB_W      = 24;  // rgb sits in dat[8:31]
   localparam int STATUS_W   = 3;   // drive activity in dat[29:31]

   // ctrl word: dat[25] green, dat[26] red, dat[27:31] sw_reset
   localparam int CTRL_W = 2 + SW_RESET_W;
   localparam logic [0:CTRL_W-1] CTRL_RESET = '0;

endpackage

// File: logic/sp_bus_pkg.sv
package sp_bus_pkg;

   // master side of the data bus, big-endian numbering throughout
   localparam int DATA_W = 32;
   localparam int ADR_W  = 32;
   localparam int SEL_W  = 4;      // one enable per byte lane, bit 0 is byte 0

   // external byte bus
   localparam int BYTE_ADR_W = 24;
   localparam int BYTE_W     = 8;

   // region codes in adr[0:7]
   localparam logic [0:7] REGION_EXT  = 8'h80;
   localparam logic [0:7] REGION_MMIO = 8'hff;

   // local RAM, selected by adr[0] clear
   localparam int RAM_ADDR_BITS = 8;
   localparam int RAM_WORDS     = 1 << RAM_ADDR_BITS;

endpackage
